/* build.f */
commit_pkg.sv
commit_ctrl.sv
perf_counters.sv
csr_regfile.sv
commit_stage.sv
commit_unit_top.sv
tb_commit_unit.sv

/* tb_commit_unit.sv */
/*
  testbench for the commit and trap unit
  applies a table of scoreboard entries and checks writeback,
  redirect, flush and CSR state against a model of the CSRs
*/

`timescale 1ns/10ps

module tb_commit_unit;

  // one table row holds the entry and its expected outcome
  typedef struct packed {
    commit_pkg::commit_entry_t         entry;
    logic                              exp_we;
    logic [commit_pkg::reg_addr_w-1:0] exp_waddr;
    logic [commit_pkg::xlen-1:0]       exp_wdata;
    logic                              keep_mcycle;
    logic                              check_rising;
    logic                              exp_redir;
    logic [commit_pkg::xlen-1:0]       exp_target;
    logic [3:0]                        halt_cycles;
  } row_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      entry_valid_i;
  commit_pkg::commit_entry_t entry_i;
  logic                      halt_i;
  logic                      entry_ack_o;
  commit_pkg::wb_t           wb_o;
  commit_pkg::redirect_t     redirect_o;
  logic                      flush_o;

  row_t        rows[$];
  string       names[$];
  logic [31:0] lfsr_q;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mscratch;
  logic [31:0] m_minstret;
  logic [31:0] mcycle_seen;
  int          errors;
  int          rows_ok;
  int          rows_bad;
  bit          table_ready;

  commit_unit_top dut_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .entry_valid_i ( entry_valid_i ),
    .entry_i       ( entry_i       ),
    .halt_i        ( halt_i        ),
    .entry_ack_o   ( entry_ack_o   ),
    .wb_o          ( wb_o          ),
    .redirect_o    ( redirect_o    ),
    .flush_o       ( flush_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // random numbers and CSR model
  // --------------------------------------------------
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < width; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // top bit flags a known address
  function automatic logic [32:0] model_read(input logic [11:0] addr);
    case (addr)
      commit_pkg::csr_mtvec:    return {1'b1, m_mtvec};
      commit_pkg::csr_mepc:     return {1'b1, m_mepc};
      commit_pkg::csr_mcause:   return {1'b1, m_mcause};
      commit_pkg::csr_mscratch: return {1'b1, m_mscratch};
      commit_pkg::csr_mcycle:   return {1'b1, 32'h0};
      commit_pkg::csr_minstret: return {1'b1, m_minstret};
      default:                  return {1'b0, 32'h0};
    endcase
  endfunction

  function automatic logic [31:0] entry_pc();
    return 32'h8000_0000 + 32'(rows.size()) * 32'd4;
  endfunction

  task automatic take_trap(inout row_t r, input logic [3:0] cause);
    r.exp_redir  = 1'b1;
    r.exp_target = m_mtvec;
    m_mepc       = r.entry.pc;
    m_mcause     = {28'h0, cause};
  endtask

  // --------------------------------------------------
  // table builders
  // --------------------------------------------------
  task automatic alu_row(input string name, input logic [4:0] rd, input int halt);
    row_t r;
    r = '0;
    r.entry.op     = commit_pkg::op_alu;
    r.entry.pc     = entry_pc();
    r.entry.rd     = rd;
    r.entry.result = random_bits(32);
    r.exp_we       = (rd != 5'd0);
    r.exp_waddr    = rd;
    r.exp_wdata    = r.entry.result;
    r.halt_cycles  = 4'(halt);
    m_minstret     = m_minstret + 1;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic csrrw_row(input string name, input logic [4:0] rd, input logic [11:0] addr,
                           input bit keep, input bit rising);
    row_t        r;
    logic [32:0] old;
    r = '0;
    r.entry.op       = commit_pkg::op_csrrw;
    r.entry.pc       = entry_pc();
    r.entry.rd       = rd;
    r.entry.csr_addr = addr;
    r.entry.result   = random_bits(32);
    old = model_read(addr);
    if (old[32]) begin
      r.exp_we       = (rd != 5'd0);
      r.exp_waddr    = rd;
      r.exp_wdata    = old[31:0];
      r.keep_mcycle  = keep;
      r.check_rising = rising;
      case (addr)
        commit_pkg::csr_mtvec:    m_mtvec    = r.entry.result;
        commit_pkg::csr_mepc:     m_mepc     = r.entry.result;
        commit_pkg::csr_mcause:   m_mcause   = r.entry.result;
        commit_pkg::csr_mscratch: m_mscratch = r.entry.result;
        default: ;
      endcase
      m_minstret = m_minstret + 1;
    end else begin
      take_trap(r, commit_pkg::cause_illegal_instr);
    end
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic exception_row(input string name, input logic [4:0] rd, input logic [3:0] cause);
    row_t r;
    r = '0;
    r.entry.op       = commit_pkg::op_alu;
    r.entry.pc       = entry_pc();
    r.entry.rd       = rd;
    r.entry.result   = random_bits(32);
    r.entry.ex_valid = 1'b1;
    r.entry.ex_cause = cause;
    take_trap(r, cause);
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic mret_row(input string name);
    row_t r;
    r = '0;
    r.entry.op   = commit_pkg::op_mret;
    r.entry.pc   = entry_pc();
    r.entry.rd   = 5'd20;
    r.exp_redir  = 1'b1;
    r.exp_target = m_mepc;
    m_minstret   = m_minstret + 1;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    alu_row("alu_x5", 5'd5, 0);
    alu_row("alu_x0", 5'd0, 0);
    alu_row("alu_x31", 5'd31, 0);
    csrrw_row("set_mtvec", 5'd1, commit_pkg::csr_mtvec, 0, 0);
    csrrw_row("swap_mscratch", 5'd2, commit_pkg::csr_mscratch, 0, 0);
    csrrw_row("read_mscratch", 5'd3, commit_pkg::csr_mscratch, 0, 0);
    csrrw_row("write_minstret", 5'd4, commit_pkg::csr_minstret, 0, 0);
    csrrw_row("read_minstret", 5'd6, commit_pkg::csr_minstret, 0, 0);
    exception_row("exception_cause5", 5'd9, 4'd5);
    csrrw_row("mcause_after_exc", 5'd7, commit_pkg::csr_mcause, 0, 0);
    csrrw_row("mepc_after_exc", 5'd8, commit_pkg::csr_mepc, 0, 0);
    csrrw_row("unknown_csr", 5'd9, 12'h7C0, 0, 0);
    csrrw_row("mcause_after_csr", 5'd10, commit_pkg::csr_mcause, 0, 0);
    csrrw_row("mepc_after_csr", 5'd11, commit_pkg::csr_mepc, 0, 0);
    mret_row("mret");
    alu_row("alu_after_halt", 5'd12, 1 + int'(random_bits(3)));
    csrrw_row("minstret_count", 5'd13, commit_pkg::csr_minstret, 0, 0);
    csrrw_row("mcycle_first", 5'd14, commit_pkg::csr_mcycle, 1, 0);
    alu_row("alu_x15", 5'd15, 0);
    csrrw_row("mcycle_second", 5'd16, commit_pkg::csr_mcycle, 0, 1);
  endtask

  // --------------------------------------------------
  // checking and row execution
  // --------------------------------------------------
  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_outcome(input string name, input row_t r);
    compare_value({name, " wb_we"}, 32'(r.exp_we), 32'(wb_o.we));
    if (r.exp_we) begin
      compare_value({name, " wb_waddr"}, 32'(r.exp_waddr), 32'(wb_o.waddr));
      if (r.check_rising) begin
        compare_value({name, " mcycle_rising"}, 32'd1, 32'(wb_o.wdata > mcycle_seen));
      end else if (!r.keep_mcycle) begin
        compare_value({name, " wb_wdata"}, r.exp_wdata, wb_o.wdata);
      end
      if (r.keep_mcycle) begin
        mcycle_seen = wb_o.wdata;
      end
    end
    if (r.exp_redir && !redirect_o.valid) begin
      $display("%s: redirect did not arrive one cycle after ack", name);
      errors++;
    end else begin
      compare_value({name, " redirect_valid"}, 32'(r.exp_redir), 32'(redirect_o.valid));
    end
    compare_value({name, " flush"}, 32'(r.exp_redir), 32'(flush_o));
    if (r.exp_redir) begin
      compare_value({name, " redirect_target"}, r.exp_target, redirect_o.target);
    end
  endtask

  task automatic run_row(input int idx);
    row_t  r;
    string name;
    int    waited;
    int    errs_before;
    r = rows[idx];
    name = names[idx];
    waited = 0;
    errs_before = errors;
    @(posedge clk_i);
    entry_valid_i <= 1'b1;
    entry_i       <= r.entry;
    if (r.halt_cycles != 0) begin
      halt_i <= 1'b1;
      repeat (r.halt_cycles) begin
        @(negedge clk_i);
        compare_value({name, " ack_in_halt"}, 32'd0, 32'(entry_ack_o));
        compare_value({name, " we_in_halt"}, 32'd0, 32'(wb_o.we));
      end
      @(posedge clk_i);
      halt_i <= 1'b0;
    end
    @(negedge clk_i);
    while (!entry_ack_o && waited < 30) begin
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    entry_valid_i <= 1'b0;
    if (waited >= 30) begin
      $display("%s: entry was never acknowledged", name);
      errors++;
    end else begin
      @(negedge clk_i);
      check_outcome(name, r);
      // the redirect is a single-cycle pulse
      @(negedge clk_i);
      compare_value({name, " redirect_end"}, 32'd0, 32'(redirect_o.valid));
      compare_value({name, " flush_end"}, 32'd0, 32'(flush_o));
    end
    if (errors == errs_before) begin
      $display("row %0d %s: ok", idx, name);
      rows_ok++;
    end else begin
      $display("row %0d %s: %0d mismatches", idx, name, errors - errs_before);
      rows_bad++;
    end
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst_ni        = 1'b0;
    entry_valid_i = 1'b0;
    entry_i       = '0;
    halt_i        = 1'b0;
    lfsr_q        = 32'd93902;
    m_mtvec       = '0;
    m_mepc        = '0;
    m_mcause      = '0;
    m_mscratch    = '0;
    m_minstret    = '0;
    mcycle_seen   = '0;
    errors        = 0;
    rows_ok       = 0;
    rows_bad      = 0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare_value("reset wb_we", 32'd0, 32'(wb_o.we));
    compare_value("reset redirect_valid", 32'd0, 32'(redirect_o.valid));
    compare_value("reset flush", 32'd0, 32'(flush_o));
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("rows run %0d, passing %0d, failing %0d", rows.size(), rows_ok, rows_bad);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 20 + 50) @(posedge clk_i);
    $display("watchdog expired before all rows finished");
    $display("test failed");
    $finish;
  end

endmodule

/* commit_unit_top.sv */
/*
  commit and trap unit top level
  connects controller, commit datapath, CSR file and counters
*/

`timescale 1ns/10ps

module commit_unit_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      entry_valid_i,
  input  commit_pkg::commit_entry_t entry_i,
  input  logic                      halt_i,
  output logic                      entry_ack_o,
  output commit_pkg::wb_t           wb_o,
  output commit_pkg::redirect_t     redirect_o,
  output logic                      flush_o
);

  // --------------------------------------------------
  // internal wiring
  // --------------------------------------------------
  commit_pkg::csr_req_t        csr_req;
  commit_pkg::redirect_t       redirect_req;
  commit_pkg::perf_t           perf;
  logic [commit_pkg::xlen-1:0] csr_rdata;
  logic                        trap;
  logic                        retire;

  commit_ctrl commit_ctrl_i (
    .clk_i          ( clk_i         ),
    .rst_ni         ( rst_ni        ),
    .entry_valid_i  ( entry_valid_i ),
    .halt_i         ( halt_i        ),
    .redirect_req_i ( redirect_req  ),
    .entry_ack_o    ( entry_ack_o   ),
    .redirect_o     ( redirect_o    ),
    .flush_o        ( flush_o       )
  );

  commit_stage commit_stage_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .entry_i     ( entry_i     ),
    .ack_i       ( entry_ack_o ),
    .trap_i      ( trap        ),
    .csr_rdata_i ( csr_rdata   ),
    .csr_req_o   ( csr_req     ),
    .retire_o    ( retire      ),
    .wb_o        ( wb_o        )
  );

  csr_regfile csr_regfile_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .csr_req_i      ( csr_req      ),
    .perf_i         ( perf         ),
    .csr_rdata_o    ( csr_rdata    ),
    .trap_o         ( trap         ),
    .redirect_req_o ( redirect_req )
  );

  perf_counters perf_counters_i (
    .clk_i    ( clk_i  ),
    .rst_ni   ( rst_ni ),
    .retire_i ( retire ),
    .perf_o   ( perf   )
  );

endmodule

/* commit_stage.sv */
/*
  commit datapath
  forms the CSR request from the acknowledged entry and
  registers the register file write one cycle later
*/

`timescale 1ns/10ps

module commit_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  commit_pkg::commit_entry_t   entry_i,
  input  logic                        ack_i,
  input  logic                        trap_i,
  input  logic [commit_pkg::xlen-1:0] csr_rdata_i,
  output commit_pkg::csr_req_t        csr_req_o,
  output logic                        retire_o,
  output commit_pkg::wb_t             wb_o
);

  logic                              wb_we_d;
  logic                              wb_we_q;
  logic [commit_pkg::reg_addr_w-1:0] wb_waddr_q;
  logic [commit_pkg::xlen-1:0]       wb_wdata_d;
  logic [commit_pkg::xlen-1:0]       wb_wdata_q;

  // --------------------------------------------------
  // CSR request
  // --------------------------------------------------
  assign csr_req_o.valid    = ack_i;
  assign csr_req_o.op       = entry_i.op;
  assign csr_req_o.addr     = entry_i.csr_addr;
  assign csr_req_o.wdata    = entry_i.result;
  assign csr_req_o.pc       = entry_i.pc;
  assign csr_req_o.ex_valid = entry_i.ex_valid;
  assign csr_req_o.ex_cause = entry_i.ex_cause;

  // mret also retires, only traps are excluded
  assign retire_o = ack_i & ~trap_i;

  // --------------------------------------------------
  // writeback select
  // --------------------------------------------------
  assign wb_we_d = retire_o & (entry_i.rd != '0) & (entry_i.op != commit_pkg::op_mret);

  // CSRRW returns the old CSR value
  assign wb_wdata_d = (entry_i.op == commit_pkg::op_csrrw) ? csr_rdata_i : entry_i.result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= wb_we_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_we_d) begin
      wb_waddr_q <= entry_i.rd;
      wb_wdata_q <= wb_wdata_d;
    end
  end

  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = wb_wdata_q;

endmodule

/* csr_regfile.sv */
/*
  machine CSR file
  holds mtvec, mepc, mcause and mscratch, serves CSR reads,
  decides trap versus retire and supplies the redirect target
*/

`timescale 1ns/10ps

module csr_regfile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  commit_pkg::csr_req_t        csr_req_i,
  input  commit_pkg::perf_t           perf_i,
  output logic [commit_pkg::xlen-1:0] csr_rdata_o,
  output logic                        trap_o,
  output commit_pkg::redirect_t       redirect_req_o
);

  logic [commit_pkg::xlen-1:0]    mtvec_q;
  logic [commit_pkg::xlen-1:0]    mepc_q;
  logic [commit_pkg::xlen-1:0]    mcause_q;
  logic [commit_pkg::xlen-1:0]    mscratch_q;
  logic                           addr_known;
  logic                           is_csrrw;
  logic                           is_mret;
  logic [commit_pkg::cause_w-1:0] trap_cause;

  // --------------------------------------------------
  // read decode
  // --------------------------------------------------
  always_comb begin
    addr_known  = 1'b1;
    csr_rdata_o = '0;
    unique case (csr_req_i.addr)
      commit_pkg::csr_mtvec:    csr_rdata_o = mtvec_q;
      commit_pkg::csr_mepc:     csr_rdata_o = mepc_q;
      commit_pkg::csr_mcause:   csr_rdata_o = mcause_q;
      commit_pkg::csr_mscratch: csr_rdata_o = mscratch_q;
      commit_pkg::csr_mcycle:   csr_rdata_o = perf_i.mcycle;
      commit_pkg::csr_minstret: csr_rdata_o = perf_i.minstret;
      default:                  addr_known  = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // trap and return decision
  // --------------------------------------------------
  assign is_csrrw = (csr_req_i.op == commit_pkg::op_csrrw);
  assign is_mret  = (csr_req_i.op == commit_pkg::op_mret);

  assign trap_o = csr_req_i.valid & (csr_req_i.ex_valid | (is_csrrw & ~addr_known));

  // upstream exception first, else the unknown CSR
  assign trap_cause = csr_req_i.ex_valid ? csr_req_i.ex_cause
                                         : commit_pkg::cause_illegal_instr;

  assign redirect_req_o.valid  = trap_o | (csr_req_i.valid & is_mret);
  assign redirect_req_o.target = trap_o ? mtvec_q : mepc_q;

  // --------------------------------------------------
  // CSR updates on the acknowledging edge
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else if (trap_o) begin
      mepc_q   <= csr_req_i.pc;
      mcause_q <= {{(commit_pkg::xlen-commit_pkg::cause_w){1'b0}}, trap_cause};
    end else if (csr_req_i.valid && is_csrrw) begin
      // counters are read-only here
      unique case (csr_req_i.addr)
        commit_pkg::csr_mtvec:    mtvec_q    <= csr_req_i.wdata;
        commit_pkg::csr_mepc:     mepc_q     <= csr_req_i.wdata;
        commit_pkg::csr_mcause:   mcause_q   <= csr_req_i.wdata;
        commit_pkg::csr_mscratch: mscratch_q <= csr_req_i.wdata;
        default: ;
      endcase
    end
  end

endmodule

/* perf_counters.sv */
/*
  performance counters
  free-running mcycle and retired-instruction minstret,
  both full width and wrapping
*/

`timescale 1ns/10ps

module perf_counters (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              retire_i,
  output commit_pkg::perf_t perf_o
);

  logic [commit_pkg::xlen-1:0] mcycle_q;
  logic [commit_pkg::xlen-1:0] minstret_q;

  // --------------------------------------------------
  // cycle counter
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // retired instructions
  // --------------------------------------------------
  // counts on the same edge as the retiring handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      minstret_q <= '0;
    end else if (retire_i) begin
      minstret_q <= minstret_q + 1'b1;
    end
  end

  assign perf_o.mcycle   = mcycle_q;
  assign perf_o.minstret = minstret_q;

endmodule

/* commit_ctrl.sv */
/*
  commit controller
  gates retirement, turns a redirect request into a one-cycle
  redirect and flush pulse, and parks the unit while halted
*/

`timescale 1ns/10ps

module commit_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  entry_valid_i,
  input  logic                  halt_i,
  input  commit_pkg::redirect_t redirect_req_i,
  output logic                  entry_ack_o,
  output commit_pkg::redirect_t redirect_o,
  output logic                  flush_o
);

  commit_pkg::ctrl_state_e state_q, state_d;
  logic [commit_pkg::xlen-1:0] target_q;

  // retire only while running and not being halted this cycle
  assign entry_ack_o = entry_valid_i & ~halt_i & (state_q == commit_pkg::st_run);

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      commit_pkg::st_run: begin
        // redirect wins over halt so it never gets lost
        if (redirect_req_i.valid) begin
          state_d = commit_pkg::st_redirect;
        end else if (halt_i) begin
          state_d = commit_pkg::st_halt;
        end
      end
      commit_pkg::st_redirect: begin
        state_d = halt_i ? commit_pkg::st_halt : commit_pkg::st_run;
      end
      commit_pkg::st_halt: begin
        if (!halt_i) begin
          state_d = commit_pkg::st_run;
        end
      end
      default: state_d = commit_pkg::st_halt;
    endcase
  end

  // leave reset in halt so ack stays low until the first clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= commit_pkg::st_halt;
    end else begin
      state_q <= state_d;
    end
  end

  // target follows the request taken in st_run
  always_ff @(posedge clk_i) begin
    if (redirect_req_i.valid) begin
      target_q <= redirect_req_i.target;
    end
  end

  // --------------------------------------------------
  // redirect and flush pulse
  // --------------------------------------------------
  assign redirect_o.valid  = (state_q == commit_pkg::st_redirect);
  assign redirect_o.target = target_q;
  assign flush_o           = (state_q == commit_pkg::st_redirect);

endmodule

/* commit_pkg.sv */
/*
  commit package
  widths, machine CSR addresses, opcode and state enums, and the
  packed structs shared by the commit and trap unit
*/

package commit_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;
  localparam int cause_w    = 4;

  // --------------------------------------------------
  // machine CSR addresses
  // --------------------------------------------------
  localparam logic [csr_addr_w-1:0] csr_mtvec    = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mcycle   = 12'hB00;
  localparam logic [csr_addr_w-1:0] csr_minstret = 12'hB02;

  // raised for an unknown CSR address
  localparam logic [cause_w-1:0] cause_illegal_instr = 4'd2;

  typedef enum logic [1:0] {
    op_alu,
    op_csrrw,
    op_mret
  } commit_op_e;

  typedef enum logic [1:0] {
    st_run,
    st_redirect,
    st_halt
  } ctrl_state_e;

  // one finished instruction from the scoreboard
  typedef struct packed {
    commit_op_e              op;
    logic [xlen-1:0]         pc;
    logic [reg_addr_w-1:0]   rd;
    logic [csr_addr_w-1:0]   csr_addr;
    logic [xlen-1:0]         result;
    logic                    ex_valid;
    logic [cause_w-1:0]      ex_cause;
  } commit_entry_t;

  // register file write port
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wb_t;

  typedef struct packed {
    logic                  valid;
    commit_op_e            op;
    logic [csr_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic [xlen-1:0]       pc;
    logic                  ex_valid;
    logic [cause_w-1:0]    ex_cause;
  } csr_req_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [xlen-1:0] mcycle;
    logic [xlen-1:0] minstret;
  } perf_t;

endpackage
